/* Makefile */
TOP = tb_noc_axil_bridge

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^all tests passed$$" sim.log

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* design/axil_ctrl_master.sv */
`timescale 1ns/100ps

module axil_ctrl_master (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_msg_pkg::noc_req_t    req,
    input  logic                     req_valid,
    input  axil_pkg::axil_rsp_t      axi_rsp,
    input  logic                     resp_busy,
    output logic                     req_take,
    output axil_pkg::axil_req_t      axi_req,
    output noc_msg_pkg::noc_result_t result,
    output logic                     result_valid
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_read,
        st_done
    } state_t;

    state_t                           state;
    noc_msg_pkg::noc_req_t            cur;
    logic [axil_pkg::axil_data_w-1:0] rdata_q;
    logic                             aw_done;
    logic                             w_done;
    logic                             ar_done;
    logic                             aw_go;
    logic                             w_go;
    logic                             ar_go;
    logic                             b_go;
    logic                             r_go;

    assign req_take     = (state == st_idle) && req_valid;
    // hold the result until the builder is free
    assign result_valid = (state == st_done) && !resp_busy;

    // valids live until their own handshake sets the done flag
    always_comb begin
        axi_req.awvalid = (state == st_write) && !aw_done;
        axi_req.awaddr  = cur.addr;
        axi_req.wvalid  = (state == st_write) && !w_done;
        axi_req.wdata   = cur.wdata;
        axi_req.wstrb   = '1;
        axi_req.bready  = (state == st_write) && aw_done && w_done;
        axi_req.arvalid = (state == st_read) && !ar_done;
        axi_req.araddr  = cur.addr;
        axi_req.rready  = (state == st_read) && ar_done;
    end

    assign aw_go = axi_req.awvalid && axi_rsp.awready;
    assign w_go  = axi_req.wvalid && axi_rsp.wready;
    assign ar_go = axi_req.arvalid && axi_rsp.arready;
    assign b_go  = axi_req.bready && axi_rsp.bvalid;
    assign r_go  = axi_req.rready && axi_rsp.rvalid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            ar_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_take) begin
                        state   <= req.is_write ? st_write : st_read;
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                        ar_done <= 1'b0;
                    end
                end
                st_write: begin
                    if (aw_go) begin
                        aw_done <= 1'b1;
                    end
                    if (w_go) begin
                        w_done <= 1'b1;
                    end
                    // error reopens both channels next cycle
                    if (b_go && axi_rsp.bresp == axil_pkg::resp_okay) begin
                        state <= st_done;
                    end else if (b_go) begin
                        aw_done <= 1'b0;
                        w_done  <= 1'b0;
                    end
                end
                st_read: begin
                    if (ar_go) begin
                        ar_done <= 1'b1;
                    end
                    if (r_go && axi_rsp.rresp == axil_pkg::resp_okay) begin
                        state <= st_done;
                    end else if (r_go) begin
                        ar_done <= 1'b0;
                    end
                end
                default: begin
                    if (result_valid) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // local copy frees the parser for the next message
    always_ff @(posedge clk) begin
        if (req_take) begin
            cur <= req;
        end
        if (r_go && axi_rsp.rresp == axil_pkg::resp_okay) begin
            rdata_q <= axi_rsp.rdata;
        end
    end

    always_comb begin
        result.is_write = cur.is_write;
        result.nc       = cur.nc;
        result.mshr     = cur.mshr;
        result.chipid   = cur.chipid;
        result.x        = cur.x;
        result.y        = cur.y;
        result.rdata    = rdata_q;
    end

endmodule

/* design/axil_pkg.sv */
package axil_pkg;

    // control port sizes
    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;
    localparam int axil_strb_w = axil_data_w / 8;

    typedef logic [1:0] axil_resp_t;

    // bresp / rresp codes
    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    // driven by the bridge
    typedef struct packed {
        logic                   awvalid;
        logic [axil_addr_w-1:0] awaddr;
        logic                   wvalid;
        logic [axil_data_w-1:0] wdata;
        logic [axil_strb_w-1:0] wstrb;
        logic                   bready;
        logic                   arvalid;
        logic [axil_addr_w-1:0] araddr;
        logic                   rready;
    } axil_req_t;

    // driven by the register slave
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        axil_resp_t             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [axil_data_w-1:0] rdata;
        axil_resp_t             rresp;
    } axil_rsp_t;

endpackage

/* design/noc_axil_ctrl_bridge.sv */
`timescale 1ns/100ps

module noc_axil_ctrl_bridge (
    input  logic                   clk,
    input  logic                   rst,
    // request side
    input  logic                   in_val,
    input  noc_msg_pkg::noc_flit_t in_data,
    output logic                   in_rdy,
    // acknowledge side
    output logic                   out_val,
    output noc_msg_pkg::noc_flit_t out_data,
    input  logic                   out_rdy,
    // control register port
    output axil_pkg::axil_req_t    axi_req,
    input  axil_pkg::axil_rsp_t    axi_rsp
);

    // parser to master
    noc_msg_pkg::noc_req_t    req;
    logic                     req_valid;
    logic                     req_take;

    // master to builder
    noc_msg_pkg::noc_result_t result;
    logic                     result_valid;
    logic                     resp_busy;

    noc_req_parser u_parser (
        .clk       (clk),
        .rst       (rst),
        .in_val    (in_val),
        .in_data   (in_data),
        .req_take  (req_take),
        .in_rdy    (in_rdy),
        .req       (req),
        .req_valid (req_valid)
    );

    axil_ctrl_master u_master (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .axi_rsp      (axi_rsp),
        .resp_busy    (resp_busy),
        .req_take     (req_take),
        .axi_req      (axi_req),
        .result       (result),
        .result_valid (result_valid)
    );

    noc_resp_builder u_builder (
        .clk          (clk),
        .rst          (rst),
        .result       (result),
        .result_valid (result_valid),
        .out_rdy      (out_rdy),
        .out_val      (out_val),
        .out_data     (out_data),
        .resp_busy    (resp_busy)
    );

endmodule

/* design/noc_msg_pkg.sv */
package noc_msg_pkg;

    // flit and header field widths
    localparam int noc_data_w = 64;
    localparam int chipid_w   = 14;
    localparam int coord_w    = 8;
    localparam int fbits_w    = 4;
    localparam int len_w      = 8;
    localparam int type_w     = 8;
    localparam int mshr_w     = 8;

    typedef logic [noc_data_w-1:0] noc_flit_t;
    typedef logic [chipid_w-1:0]   noc_chipid_t;
    typedef logic [coord_w-1:0]    noc_coord_t;
    typedef logic [len_w-1:0]      noc_len_t;
    typedef logic [type_w-1:0]     noc_type_t;
    typedef logic [mshr_w-1:0]     noc_mshr_t;

    // request message types
    localparam noc_type_t msg_load_mem     = 8'd19;
    localparam noc_type_t msg_store_mem    = 8'd20;
    localparam noc_type_t msg_nc_load_req  = 8'd14;
    localparam noc_type_t msg_nc_store_req = 8'd15;

    // acknowledge types
    localparam noc_type_t msg_load_mem_ack     = 8'd24;
    localparam noc_type_t msg_store_mem_ack    = 8'd25;
    localparam noc_type_t msg_nc_load_mem_ack  = 8'd26;
    localparam noc_type_t msg_nc_store_mem_ack = 8'd27;

    // header flit 1, msb first: 63..50 chip, 49..42 x, 41..34 y,
    // 33..30 fbits, 29..22 length, 21..14 type, 13..6 mshr
    typedef struct packed {
        noc_chipid_t        chipid;
        noc_coord_t         x;
        noc_coord_t         y;
        logic [fbits_w-1:0] fbits;
        noc_len_t           len;
        noc_type_t          msg_type;
        noc_mshr_t          mshr;
        logic [5:0]         rsvd;
    } noc_hdr1_t;

    // header flit 2, control register address at 23..16
    typedef struct packed {
        logic [39:0] rsvd_hi;
        logic [7:0]  addr;
        logic [15:0] rsvd_lo;
    } noc_hdr2_t;

    // header flit 3, requester coordinates
    typedef struct packed {
        noc_chipid_t src_chipid;
        noc_coord_t  src_x;
        noc_coord_t  src_y;
        logic [33:0] rsvd;
    } noc_hdr3_t;

    // captured request, parser to master
    typedef struct packed {
        logic                             is_write;
        logic                             nc;
        noc_mshr_t                        mshr;
        logic [axil_pkg::axil_addr_w-1:0] addr;
        logic [axil_pkg::axil_data_w-1:0] wdata;
        noc_chipid_t                      chipid;
        noc_coord_t                       x;
        noc_coord_t                       y;
    } noc_req_t;

    // finished request, master to builder
    typedef struct packed {
        logic                             is_write;
        logic                             nc;
        noc_mshr_t                        mshr;
        noc_chipid_t                      chipid;
        noc_coord_t                       x;
        noc_coord_t                       y;
        logic [axil_pkg::axil_data_w-1:0] rdata;
    } noc_result_t;

endpackage

/* design/noc_req_parser.sv */
`timescale 1ns/100ps

module noc_req_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_val,
    input  noc_msg_pkg::noc_flit_t in_data,
    input  logic                   req_take,
    output logic                   in_rdy,
    output noc_msg_pkg::noc_req_t  req,
    output logic                   req_valid
);

    typedef enum logic [2:0] {
        st_reset,
        st_hdr1,
        st_hdr2,
        st_hdr3,
        st_data,
        st_drain,
        st_throw
    } state_t;

    state_t                 state;
    state_t                 state_next;
    noc_msg_pkg::noc_len_t  flit_cnt;
    noc_msg_pkg::noc_len_t  msg_len;
    noc_msg_pkg::noc_hdr1_t hdr1;
    noc_msg_pkg::noc_hdr2_t hdr2;
    noc_msg_pkg::noc_hdr3_t hdr3;
    logic                   in_go;
    logic                   last_flit;
    logic                   is_load;
    logic                   is_store;
    logic                   supported;
    logic                   req_done;

    // same flit seen through each header layout
    assign hdr1 = in_data;
    assign hdr2 = in_data;
    assign hdr3 = in_data;

    assign in_go     = in_val && in_rdy;
    // counter holds flits taken after header 1
    assign last_flit = (flit_cnt == msg_len - noc_msg_pkg::noc_len_t'(1));

    assign is_load  = (hdr1.msg_type == noc_msg_pkg::msg_load_mem) ||
                      (hdr1.msg_type == noc_msg_pkg::msg_nc_load_req);
    assign is_store = (hdr1.msg_type == noc_msg_pkg::msg_store_mem) ||
                      (hdr1.msg_type == noc_msg_pkg::msg_nc_store_req);
    // needs at least headers 2 and 3
    assign supported = (is_load || is_store) && (hdr1.len >= noc_msg_pkg::noc_len_t'(2));

    // load ends at header 3, store at its first data flit
    assign req_done = in_go && (state == st_data ||
                      (state == st_hdr3 && (!req.is_write || last_flit)));

    // stall a new message while the previous request waits
    always_comb begin
        case (state)
            st_reset: in_rdy = 1'b0;
            st_hdr1:  in_rdy = !req_valid;
            default:  in_rdy = 1'b1;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_reset: state_next = st_hdr1;
            st_hdr1: begin
                if (in_go && supported) begin
                    state_next = st_hdr2;
                end else if (in_go && hdr1.len != '0) begin
                    state_next = st_throw;
                end
            end
            st_hdr2: begin
                if (in_go) begin
                    state_next = st_hdr3;
                end
            end
            st_hdr3, st_data: begin
                if (in_go && last_flit) begin
                    state_next = st_hdr1;
                end else if (in_go && state == st_hdr3 && req.is_write) begin
                    state_next = st_data;
                end else if (in_go) begin
                    // trailing store data or oversized load
                    state_next = st_drain;
                end
            end
            default: begin
                // drain and throw just count to the end
                if (in_go && last_flit) begin
                    state_next = st_hdr1;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= st_reset;
            flit_cnt  <= '0;
            msg_len   <= '0;
            req_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (state == st_hdr1 && in_go) begin
                flit_cnt <= '0;
                msg_len  <= hdr1.len;
            end else if (in_go) begin
                flit_cnt <= flit_cnt + noc_msg_pkg::noc_len_t'(1);
            end
            if (req_done) begin
                req_valid <= 1'b1;
            end else if (req_take) begin
                req_valid <= 1'b0;
            end
        end
    end

    // request fields, only written while no request is pending
    always_ff @(posedge clk) begin
        if (state == st_hdr1 && in_go) begin
            req.is_write <= is_store;
            req.nc       <= (hdr1.msg_type == noc_msg_pkg::msg_nc_load_req) ||
                            (hdr1.msg_type == noc_msg_pkg::msg_nc_store_req);
            req.mshr     <= hdr1.mshr;
            // store without data writes zero
            req.wdata    <= '0;
        end
        if (state == st_hdr2 && in_go) begin
            req.addr <= hdr2.addr;
        end
        if (state == st_hdr3 && in_go) begin
            req.chipid <= hdr3.src_chipid;
            req.x      <= hdr3.src_x;
            req.y      <= hdr3.src_y;
        end
        // low word of the first data flit
        if (state == st_data && in_go) begin
            req.wdata <= in_data[axil_pkg::axil_data_w-1:0];
        end
    end

endmodule

/* design/noc_resp_builder.sv */
`timescale 1ns/100ps

module noc_resp_builder (
    input  logic                     clk,
    input  logic                     rst,
    input  noc_msg_pkg::noc_result_t result,
    input  logic                     result_valid,
    input  logic                     out_rdy,
    output logic                     out_val,
    output noc_msg_pkg::noc_flit_t   out_data,
    output logic                     resp_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_hdr,
        st_data
    } state_t;

    state_t                   state;
    noc_msg_pkg::noc_result_t res_q;
    noc_msg_pkg::noc_hdr1_t   hdr;
    noc_msg_pkg::noc_type_t   ack_type;
    noc_msg_pkg::noc_flit_t   data_flit;
    logic                     out_go;

    assign out_go = out_val && out_rdy;

    // ack code from write and non-cacheable bits
    always_comb begin
        case ({res_q.is_write, res_q.nc})
            2'b00:   ack_type = noc_msg_pkg::msg_load_mem_ack;
            2'b01:   ack_type = noc_msg_pkg::msg_nc_load_mem_ack;
            2'b10:   ack_type = noc_msg_pkg::msg_store_mem_ack;
            default: ack_type = noc_msg_pkg::msg_nc_store_mem_ack;
        endcase
    end

    // route back to the requester, one data flit for loads
    always_comb begin
        hdr.chipid   = res_q.chipid;
        hdr.x        = res_q.x;
        hdr.y        = res_q.y;
        hdr.fbits    = '0;
        hdr.len      = res_q.is_write ? '0 : noc_msg_pkg::noc_len_t'(1);
        hdr.msg_type = ack_type;
        hdr.mshr     = res_q.mshr;
        hdr.rsvd     = '0;
    end

    // read word zero-extended into the flit
    assign data_flit = {{(noc_msg_pkg::noc_data_w - axil_pkg::axil_data_w){1'b0}}, res_q.rdata};

    assign out_val   = (state != st_idle);
    assign resp_busy = (state != st_idle);
    assign out_data  = (state == st_data) ? data_flit : hdr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (result_valid) begin
                        state <= st_hdr;
                    end
                end
                st_hdr: begin
                    if (out_go) begin
                        state <= res_q.is_write ? st_idle : st_data;
                    end
                end
                default: begin
                    if (out_go) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // master only pulses while we are idle
    always_ff @(posedge clk) begin
        if (state == st_idle && result_valid) begin
            res_q <= result;
        end
    end

endmodule

/* files.f */
design/axil_pkg.sv
design/noc_msg_pkg.sv
design/noc_req_parser.sv
design/axil_ctrl_master.sv
design/noc_resp_builder.sv
design/noc_axil_ctrl_bridge.sv
verification/axil_reg_model.sv
verification/tb_noc_axil_bridge.sv

/* verification/axil_reg_model.sv */
`timescale 1ns/100ps

module axil_reg_model #(
    parameter logic [31:0] seed = 32'h916f3541
) (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axi_req,
    output axil_pkg::axil_rsp_t axi_rsp
);

    // one-shot error address for both directions
    localparam logic [axil_pkg::axil_addr_w-1:0] err_addr = 8'he0;

    logic [axil_pkg::axil_data_w-1:0] regs [16];
    logic [31:0]                      lfsr;
    logic                             aw_got;
    logic                             w_got;
    logic [axil_pkg::axil_addr_w-1:0] awaddr_q;
    logic [axil_pkg::axil_data_w-1:0] wdata_q;
    logic                             w_err_used;
    logic                             r_err_used;
    logic                             bvalid;
    axil_pkg::axil_resp_t             bresp;
    logic                             rvalid;
    logic [axil_pkg::axil_data_w-1:0] rdata;
    axil_pkg::axil_resp_t             rresp;

    // taps 32 22 2 1, new bit enters at the bottom
    function automatic logic [31:0] shift_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // three fresh bits per cycle, one for each ready
    always_comb begin
        axi_rsp.awready = !aw_got && !bvalid && lfsr[0];
        axi_rsp.wready  = !w_got && !bvalid && lfsr[1];
        axi_rsp.bvalid  = bvalid;
        axi_rsp.bresp   = bresp;
        axi_rsp.arready = !rvalid && lfsr[2];
        axi_rsp.rvalid  = rvalid;
        axi_rsp.rdata   = rdata;
        axi_rsp.rresp   = rresp;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr       <= seed;
            aw_got     <= 1'b0;
            w_got      <= 1'b0;
            awaddr_q   <= '0;
            wdata_q    <= '0;
            w_err_used <= 1'b0;
            r_err_used <= 1'b0;
            bvalid     <= 1'b0;
            bresp      <= axil_pkg::resp_okay;
            rvalid     <= 1'b0;
            rdata      <= '0;
            rresp      <= axil_pkg::resp_okay;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            lfsr <= shift_lfsr(shift_lfsr(shift_lfsr(lfsr)));
            if (axi_req.awvalid && axi_rsp.awready) begin
                aw_got   <= 1'b1;
                awaddr_q <= axi_req.awaddr;
            end
            if (axi_req.wvalid && axi_rsp.wready) begin
                w_got   <= 1'b1;
                wdata_q <= axi_req.wdata;
            end
            // both halves in, answer next cycle
            if (aw_got && w_got) begin
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
                if (awaddr_q == err_addr && !w_err_used) begin
                    // rejected write leaves the register alone
                    bresp      <= axil_pkg::resp_slverr;
                    w_err_used <= 1'b1;
                end else begin
                    bresp                <= axil_pkg::resp_okay;
                    regs[awaddr_q[5:2]] <= wdata_q;
                end
            end else if (bvalid && axi_req.bready) begin
                bvalid <= 1'b0;
            end
            if (axi_req.arvalid && axi_rsp.arready) begin
                rvalid <= 1'b1;
                if (axi_req.araddr == err_addr && !r_err_used) begin
                    rresp      <= axil_pkg::resp_slverr;
                    rdata      <= '0;
                    r_err_used <= 1'b1;
                end else begin
                    rresp <= axil_pkg::resp_okay;
                    rdata <= regs[axi_req.araddr[5:2]];
                end
            end else if (rvalid && axi_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* verification/tb_noc_axil_bridge.sv */
`timescale 1ns/100ps

module tb_noc_axil_bridge;

    // about 40 messages of a few dozen cycles each plus wide margin
    localparam int timeout_cycles = 20000;

    logic                   clk;
    logic                   rst;
    logic                   in_val;
    noc_msg_pkg::noc_flit_t in_data;
    logic                   in_rdy;
    logic                   out_val;
    noc_msg_pkg::noc_flit_t out_data;
    logic                   out_rdy;
    axil_pkg::axil_req_t    axi_req;
    axil_pkg::axil_rsp_t    axi_rsp;

    logic [31:0] lfsr_state;
    // expected register contents
    logic [31:0] shadow_regs [16];
    int          cycle_cnt = 0;

    noc_axil_ctrl_bridge UUT (
        .clk      (clk),
        .rst      (rst),
        .in_val   (in_val),
        .in_data  (in_data),
        .in_rdy   (in_rdy),
        .out_val  (out_val),
        .out_data (out_data),
        .out_rdy  (out_rdy),
        .axi_req  (axi_req),
        .axi_rsp  (axi_rsp)
    );

    axil_reg_model u_reg_model (
        .clk     (clk),
        .rst     (rst),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout, no response within %0d cycles", timeout_cycles);
            $display("tests failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    // writes always carry full byte strobes
    always @(negedge clk) begin
        if (!rst && axi_req.wvalid) begin
            check_eq("wstrb", axi_req.wstrb, 4'hf);
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // requester coordinates derived from the mshr id
    function automatic logic [13:0] src_chip(input logic [7:0] mshr);
        return {6'h2b, mshr};
    endfunction

    function automatic logic [7:0] src_x(input logic [7:0] mshr);
        return mshr ^ 8'h5a;
    endfunction

    function automatic logic [7:0] src_y(input logic [7:0] mshr);
        return ~mshr;
    endfunction

    // bridge at chip 1 tile (3,4) with fbits zero
    function automatic logic [63:0] hdr1_flit(input logic [7:0] len, input logic [7:0] mtype,
                                              input logic [7:0] mshr);
        return {14'h0001, 8'h03, 8'h04, 4'h0, len, mtype, mshr, 6'h00};
    endfunction

    function automatic logic [63:0] hdr2_flit(input logic [7:0] addr);
        return {40'h0, addr, 16'h0};
    endfunction

    function automatic logic [63:0] hdr3_flit(input logic [7:0] mshr);
        return {src_chip(mshr), src_x(mshr), src_y(mshr), 34'h0};
    endfunction

    function automatic logic [7:0] ack_type_for(input logic [7:0] mtype);
        case (mtype)
            noc_msg_pkg::msg_load_mem:    return noc_msg_pkg::msg_load_mem_ack;
            noc_msg_pkg::msg_store_mem:   return noc_msg_pkg::msg_store_mem_ack;
            noc_msg_pkg::msg_nc_load_req: return noc_msg_pkg::msg_nc_load_mem_ack;
            default:                      return noc_msg_pkg::msg_nc_store_mem_ack;
        endcase
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // everything the bridge drives is quiet in reset
    task automatic expect_reset_values;
        check_eq("in_rdy", in_rdy, 0);
        check_eq("out_val", out_val, 0);
        check_eq("awvalid", axi_req.awvalid, 0);
        check_eq("wvalid", axi_req.wvalid, 0);
        check_eq("bready", axi_req.bready, 0);
        check_eq("arvalid", axi_req.arvalid, 0);
        check_eq("rready", axi_req.rready, 0);
    endtask

    // no flit may be offered for a while
    task automatic expect_no_output(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            check_eq("out_val", out_val, 0);
        end
    endtask

    // in_rdy only moves on rising edges so it is stable here
    task automatic send_flit(input logic [63:0] flit);
        @(negedge clk);
        in_val  = 1'b1;
        in_data = flit;
        while (!in_rdy) begin
            @(negedge clk);
        end
    endtask

    task automatic end_send;
        @(negedge clk);
        in_val  = 1'b0;
        in_data = '0;
    endtask

    task automatic send_request(input logic [7:0] mtype, input logic [7:0] mshr,
                                input logic [7:0] addr, input logic [31:0] wdata,
                                input int n_data);
        send_flit(hdr1_flit(8'(2 + n_data), mtype, mshr));
        send_flit(hdr2_flit(addr));
        send_flit(hdr3_flit(mshr));
        for (int i = 0; i < n_data; i++) begin
            // upper half of the first flit must be ignored
            if (i == 0) begin
                send_flit({~wdata, wdata});
            end else begin
                send_flit({32'hdead_beef, wdata + 32'(i)});
            end
        end
        end_send();
    endtask

    task automatic get_flit(input logic random_rdy, output logic [63:0] flit);
        logic        got;
        logic [31:0] bit_v;
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            if (random_rdy) begin
                take_bits(1, bit_v);
                out_rdy = bit_v[0];
            end else begin
                out_rdy = 1'b1;
            end
            if (out_val && out_rdy) begin
                flit = out_data;
                got  = 1'b1;
            end
        end
    endtask

    task automatic expect_ack(input logic [7:0] req_type, input logic [7:0] mshr,
                              input logic is_load, input logic [31:0] rdata,
                              input logic random_rdy);
        logic [63:0] flit;
        get_flit(random_rdy, flit);
        check_eq("ack chipid", flit[63:50], src_chip(mshr));
        check_eq("ack x", flit[49:42], src_x(mshr));
        check_eq("ack y", flit[41:34], src_y(mshr));
        check_eq("ack fbits", flit[33:30], 0);
        check_eq("ack length", flit[29:22], is_load ? 1 : 0);
        check_eq("ack type", flit[21:14], ack_type_for(req_type));
        check_eq("ack mshr", flit[13:6], mshr);
        check_eq("ack low bits", flit[5:0], 0);
        if (is_load) begin
            get_flit(random_rdy, flit);
            check_eq("ack data", flit, {32'h0, rdata});
        end
        @(negedge clk);
        out_rdy = 1'b0;
    endtask

    task automatic run_store(input logic [7:0] mtype, input logic [7:0] mshr,
                             input logic [7:0] addr, input logic [31:0] wdata,
                             input int n_data, input logic random_rdy);
        send_request(mtype, mshr, addr, wdata, n_data);
        shadow_regs[addr[5:2]] = wdata;
        expect_ack(mtype, mshr, 1'b0, 32'h0, random_rdy);
    endtask

    task automatic run_load(input logic [7:0] mtype, input logic [7:0] mshr,
                            input logic [7:0] addr, input logic random_rdy);
        send_request(mtype, mshr, addr, 32'h0, 0);
        expect_ack(mtype, mshr, 1'b1, shadow_regs[addr[5:2]], random_rdy);
    endtask

    task automatic store_then_load;
        run_store(noc_msg_pkg::msg_store_mem, 8'h01, 8'h10, 32'hcafe_f00d, 1, 1'b0);
        run_load(noc_msg_pkg::msg_load_mem, 8'h02, 8'h10, 1'b0);
    endtask

    task automatic nc_store_then_load;
        run_store(noc_msg_pkg::msg_nc_store_req, 8'h11, 8'h24, 32'h1234_5678, 1, 1'b0);
        run_load(noc_msg_pkg::msg_nc_load_req, 8'h12, 8'h24, 1'b0);
    endtask

    task automatic discard_unsupported;
        // unserved type 31 with five payload flits then an empty one
        send_flit(hdr1_flit(8'd5, 8'd31, 8'h21));
        for (int i = 0; i < 5; i++) begin
            send_flit({32'h0bad_0000, 32'(i)});
        end
        send_flit(hdr1_flit(8'd0, 8'd31, 8'h22));
        end_send();
        expect_no_output(50);
        // a stray ack would show up ahead of this one
        run_store(noc_msg_pkg::msg_store_mem, 8'h23, 8'h38, 32'h0f1e_2d3c, 1, 1'b0);
        run_load(noc_msg_pkg::msg_load_mem, 8'h24, 8'h38, 1'b0);
    endtask

    task automatic multi_flit_store;
        run_store(noc_msg_pkg::msg_store_mem, 8'h31, 8'h0c, 32'h5555_aaaa, 3, 1'b0);
        run_load(noc_msg_pkg::msg_load_mem, 8'h32, 8'h0c, 1'b0);
    endtask

    task automatic slverr_retry;
        run_store(noc_msg_pkg::msg_store_mem, 8'h41, 8'he0, 32'h7e57_e770, 1, 1'b0);
        check_eq("write error injected", u_reg_model.w_err_used, 1);
        run_load(noc_msg_pkg::msg_load_mem, 8'h42, 8'he0, 1'b0);
        check_eq("read error injected", u_reg_model.r_err_used, 1);
    endtask

    task automatic random_backpressure;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        logic [31:0] kind_v;
        for (int i = 0; i < 10; i++) begin
            take_bits(8, addr_v);
            take_bits(32, data_v);
            take_bits(1, kind_v);
            run_store(kind_v[0] ? noc_msg_pkg::msg_nc_store_req : noc_msg_pkg::msg_store_mem,
                      8'(8'h50 + i), addr_v[7:0], data_v, 1, 1'b1);
            // odd pairs read some other register
            if (i % 2 == 1) begin
                take_bits(8, addr_v);
            end
            take_bits(1, kind_v);
            run_load(kind_v[0] ? noc_msg_pkg::msg_nc_load_req : noc_msg_pkg::msg_load_mem,
                     8'(8'h60 + i), addr_v[7:0], 1'b1);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        in_val     = 1'b0;
        in_data    = '0;
        out_rdy    = 1'b0;
        lfsr_state = 32'h916f3541;
        for (int i = 0; i < 16; i++) begin
            shadow_regs[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_reset_values();
        rst = 1'b0;
        // parser still sits in its reset state for one cycle
        check_eq("in_rdy", in_rdy, 0);
        @(negedge clk);
        check_eq("in_rdy", in_rdy, 1);
        store_then_load();
        nc_store_then_load();
        discard_unsupported();
        multi_flit_store();
        slverr_retry();
        random_backpressure();
        $display("all tests passed");
        $finish;
    end

endmodule
